// ==== src/efifo_pkg.sv ====
// ------------------------------
// elastic buffer shared types, thresholds and patterns
// also holds the clock correction word test
// ------------------------------
package efifo_pkg;

   // ------------------------------
   // word layout
   // ------------------------------
   typedef struct packed {
      logic       idle;        // idle ordered set
      logic       sof;         // start of frame
      logic       eof;         // end of frame
      logic       data;        // frame data
      logic       code_viol;   // decode error on this lane
      logic [3:0] prim;        // one-hot primitive sequence
   } lane_t;

   typedef struct packed {
      logic [63:0] data;       // raw transmission word
      lane_t       lane1;
      lane_t       lane0;
   } word_t;

   typedef logic [7:0] stat_cnt_t;  // saturating stat value
   typedef logic [5:0] used_t;      // fifo occupancy 0..32
   typedef logic [3:0] credit_t;    // output credits

   // prim field bit positions
   localparam int PRIM_NOS = 0;
   localparam int PRIM_OLS = 1;
   localparam int PRIM_LR  = 2;
   localparam int PRIM_LRR = 3;

   // ------------------------------
   // fifo watermarks
   // ------------------------------
   localparam int    FIFO_DEPTH = 32;
   localparam used_t HIGH_LIMIT = 6'd20;   // above -> delete one ccs
   localparam used_t LOW_LIMIT  = 6'd10;   // below -> insert ccs
   localparam used_t READ_LEVEL = 6'd16;   // above -> start reading

   localparam logic [1:0] SEQ_REPEAT   = 2'd3;   // words per sequence event
   localparam logic [3:0] LINKUP_IDLES = 4'd8;   // clean idles for link up
   localparam credit_t    CREDIT_INIT  = 4'd8;

   // data patterns for inserted words, both lanes same ordered set
   localparam logic [63:0] IDLE_DATA = 64'h0000_0000_0000_001e;
   localparam logic [63:0] NOS_DATA  = 64'h4545_b500_4545_b555;
   localparam logic [63:0] OLS_DATA  = 64'h3535_b500_3535_b555;
   localparam logic [63:0] LR_DATA   = 64'h4949_b500_4949_b555;
   localparam logic [63:0] LRR_DATA  = 64'h3535_2900_3535_2955;

   // clock correction test on one word, frame look-ahead not included
   function automatic logic is_ccs(input lane_t l0, input lane_t l1);
      logic same_prim;
      logic both_idle;
      same_prim = |(l0.prim & l1.prim);    // one-hot, so any overlap is a match
      both_idle = l0.idle & l1.idle;
      return !l0.code_viol && !l1.code_viol && (both_idle || same_prim);
   endfunction

endpackage

// ==== src/efifo_fifo.sv ====
`timescale 1ns/1ps
// ------------------------------
// storage fifo for transmission words
// one cycle read latency, occupancy count, synchronous flush
// ------------------------------
module efifo_fifo
   import efifo_pkg::*;
#(
   parameter int DEPTH = FIFO_DEPTH
) (
   input  logic  clk,
   input  logic  rst_n,
   input  logic  flush,     // link down, drop everything
   input  logic  wr_en,
   input  word_t wr_word,
   input  logic  rd_en,
   output word_t rd_word,   // valid one cycle after rd_en
   output used_t used,
   output logic  empty,
   output logic  full
);
   localparam int AW = $clog2(DEPTH);

   word_t         mem [DEPTH];
   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;
   used_t         count;
   logic          do_wr;
   logic          do_rd;

   // wrap for non power of two depth
   function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] p);
      return (p == AW'(DEPTH - 1)) ? '0 : p + 1'b1;
   endfunction

   assign do_wr = wr_en & ~full;    // writes into full fifo are lost
   assign do_rd = rd_en & ~empty;
   assign full  = (count == used_t'(DEPTH));
   assign empty = (count == '0);
   assign used  = count;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else if (flush) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_wr) wr_ptr <= ptr_inc(wr_ptr);
         if (do_rd) rd_ptr <= ptr_inc(rd_ptr);
         case ({do_wr, do_rd})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;     // both or none
         endcase
      end
   end

   // storage and read data register
   always_ff @(posedge clk) begin
      if (do_wr) mem[wr_ptr] <= wr_word;
      if (do_rd) rd_word <= mem[rd_ptr];
   end

   // read side must never pop an empty fifo
   a_no_underflow : assert property (@(posedge clk) disable iff (!rst_n)
      rd_en |-> !empty);

endmodule

// ==== src/efifo_write_ctrl.sv ====
`timescale 1ns/1ps
// ------------------------------
// write side of elastic buffer
// input register, ccs detect with look-ahead, one-shot delete
// ------------------------------
module efifo_write_ctrl
   import efifo_pkg::*;
(
   input  logic  clk,
   input  logic  rst_n,
   input  word_t in_word,
   input  logic  in_valid,
   input  used_t used,          // fifo occupancy
   input  logic  full,
   output logic  wr_en,
   output word_t wr_word,       // write stage word
   output logic  wr_valid,
   output logic  delete_evt,
   output logic  overflow_evt,
   output logic  lane_ok
);

   typedef enum logic [1:0] {
      WR_IDLE,    // below high water mark
      WR_DROP,    // hunting next ccs
      WR_WAIT0,
      WR_WAIT1
   } wr_state_t;

   wr_state_t state;
   logic      next_sof;   // next word starts a frame
   logic      wr_ccs;

   // ------------------------------
   // input stage
   // ------------------------------
   always_ff @(posedge clk) begin
      wr_word <= in_word;      // payload, no reset
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) wr_valid <= 1'b0;
      else        wr_valid <= in_valid;
   end

   // ccs only if the following word does not open a frame
   assign next_sof = in_valid & (in_word.lane0.sof | in_word.lane1.sof);
   assign wr_ccs   = wr_valid & is_ccs(wr_word.lane0, wr_word.lane1) & ~next_sof;

   // ------------------------------
   // delete fsm
   // ------------------------------
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= WR_IDLE;
      end else begin
         case (state)
            WR_IDLE:  if (used > HIGH_LIMIT) state <= WR_DROP;
            WR_DROP:  if (wr_ccs) state <= WR_WAIT0;    // dropped one, back off
            WR_WAIT0: state <= WR_WAIT1;
            default:  state <= WR_IDLE;
         endcase
      end
   end

   assign delete_evt   = (state == WR_DROP) & wr_ccs;
   assign wr_en        = wr_valid & ~delete_evt;   // write all but the dropped word
   assign overflow_evt = wr_en & full;
   assign lane_ok      = wr_valid & ~wr_word.lane0.code_viol & ~wr_word.lane1.code_viol;

   // dropped word never written, and no second drop in the two wait cycles
   a_delete_spacing : assert property (@(posedge clk) disable iff (!rst_n)
      delete_evt |-> !wr_en ##1 !delete_evt [*2]);

endmodule

// ==== src/efifo_read_ctrl.sv ====
`timescale 1ns/1ps
// ------------------------------
// read side of elastic buffer
// read fsm, ccs insertion, output register, credit count
// ------------------------------
module efifo_read_ctrl
   import efifo_pkg::*;
(
   input  logic  clk,
   input  logic  rst_n,
   input  used_t used,
   input  logic  empty,
   output logic  rd_en,
   input  word_t rd_word,         // fifo data, one cycle after rd_en
   input  logic  credit_return,   // one credit back per cycle
   output word_t out_word,
   output logic  out_valid,
   output logic  insert_evt
);

   typedef enum logic [1:0] {
      RD_IDLE,      // wait for fill level
      RD_READING,
      RD_WAIT0,     // low, looking for a ccs to stretch
      RD_INSERT     // repeat the ccs
   } rd_state_t;

   rd_state_t state;
   credit_t   credits;
   logic      credit_ok;
   logic      above_read;
   logic      below_low;
   logic      rd_en_q;      // rd_word valid this cycle
   logic      rd_ccs;
   logic      insert;
   logic      insert_q;
   logic      take;         // credit consumed this cycle
   lane_t     last_ccs;
   lane_t     ccs_lane;
   word_t     ccs_word;

   assign credit_ok  = (credits != '0);
   assign above_read = (used > READ_LEVEL);
   assign below_low  = (used < LOW_LIMIT);
   assign rd_ccs     = rd_en_q & is_ccs(rd_word.lane0, rd_word.lane1);

   // reads and inserts never overlap
   assign rd_en  = ((state == RD_READING) || (state == RD_WAIT0 && !rd_ccs))
                   && !empty && credit_ok;
   assign insert = ((state == RD_WAIT0 && below_low && rd_ccs) || (state == RD_INSERT))
                   && credit_ok;
   assign take       = rd_en | insert;
   assign insert_evt = insert;

   // ------------------------------
   // read fsm
   // ------------------------------
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= RD_IDLE;
      end else begin
         case (state)
            RD_IDLE:    if (above_read) state <= RD_READING;
            RD_READING: if (below_low) state <= RD_WAIT0;
            RD_WAIT0:   state <= !below_low ? RD_READING : rd_ccs ? RD_INSERT : RD_WAIT0;
            default:    if (!below_low) state <= RD_READING;   // insert until refilled
         endcase
      end
   end

   // ------------------------------
   // credits, never above init
   // ------------------------------
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         credits <= CREDIT_INIT;
      end else begin
         case ({take, credit_return})
            2'b10:   credits <= credits - 1'b1;
            2'b01:   if (credits != CREDIT_INIT) credits <= credits + 1'b1;
            default: credits <= credits;   // take and return cancel
         endcase
      end
   end

   // last ccs seen on the read side, idle until the first one
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)      last_ccs <= '{idle: 1'b1, default: '0};
      else if (rd_ccs) last_ccs <= rd_word.lane1;
   end

   // clean copy of the remembered ccs
   always_comb begin
      ccs_lane       = '0;
      ccs_lane.idle  = last_ccs.idle;
      ccs_lane.prim  = last_ccs.prim;
      ccs_word.lane0 = ccs_lane;
      ccs_word.lane1 = ccs_lane;
      if (ccs_lane.prim[PRIM_NOS])      ccs_word.data = NOS_DATA;
      else if (ccs_lane.prim[PRIM_OLS]) ccs_word.data = OLS_DATA;
      else if (ccs_lane.prim[PRIM_LR])  ccs_word.data = LR_DATA;
      else if (ccs_lane.prim[PRIM_LRR]) ccs_word.data = LRR_DATA;
      else                              ccs_word.data = IDLE_DATA;
   end

   // ------------------------------
   // output stage
   // ------------------------------
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rd_en_q   <= 1'b0;
         insert_q  <= 1'b0;
         out_valid <= 1'b0;
      end else begin
         rd_en_q   <= rd_en;
         insert_q  <= insert;
         out_valid <= rd_en_q | insert_q;   // two cycles after decision
      end
   end

   always_ff @(posedge clk) begin
      if (insert_q)     out_word <= ccs_word;
      else if (rd_en_q) out_word <= rd_word;
   end

   // no output word unless a credit was held when it was picked
   a_credit_paid : assert property (@(posedge clk) disable iff (!rst_n)
      out_valid |-> $past(credits, 2) != '0);

endmodule

// ==== src/efifo_prim_seq.sv ====
`timescale 1ns/1ps
// ------------------------------
// primitive sequence detect, nos ols lr lrr
// event on third matching word in a row
// ------------------------------
module efifo_prim_seq
   import efifo_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,
   input  word_t      wr_word,    // write stage word
   input  logic       wr_valid,
   output logic [3:0] seq_evt     // one bit per primitive
);

   logic [3:0] both;         // prim present in both lanes
   logic [1:0] run [4];      // consecutive word count, saturates

   assign both = wr_word.lane0.prim & wr_word.lane1.prim;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < 4; i++) run[i] <= '0;
      end else if (wr_valid) begin
         for (int i = 0; i < 4; i++) begin
            if (!both[i])                run[i] <= '0;      // run broken
            else if (run[i] != SEQ_REPEAT) run[i] <= run[i] + 1'b1;
         end
      end
   end

   // fires once per run, on the word that completes it
   always_comb begin
      for (int i = 0; i < 4; i++) begin
         seq_evt[i] = wr_valid & both[i] & (run[i] == SEQ_REPEAT - 2'd1);
      end
   end

endmodule

// ==== src/efifo_link_fsm.sv ====
`timescale 1ns/1ps
// ------------------------------
// link state, up after clean idles, down on sequence event
// ------------------------------
module efifo_link_fsm
   import efifo_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,
   input  logic       lane_ok,          // valid word, no code violation
   input  word_t      wr_word,
   input  logic [3:0] seq_evt,
   output logic       link_up,
   output logic       link_up_pulse,
   output logic       link_down_pulse
);

   logic [3:0] idle_cnt;
   logic       idle_word;   // clean idle in both lanes
   logic       any_seq;
   logic       go_up;

   assign idle_word = lane_ok & wr_word.lane0.idle & wr_word.lane1.idle;
   assign any_seq   = |seq_evt;
   assign go_up     = ~link_up & idle_word & (idle_cnt == LINKUP_IDLES - 4'd1);

   // ------------------------------
   // idle counter, runs while down
   // ------------------------------
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         idle_cnt <= '0;
      end else if (link_up || any_seq) begin
         idle_cnt <= '0;                  // restart bring-up
      end else if (idle_word && !go_up) begin
         idle_cnt <= idle_cnt + 1'b1;
      end
   end

   // ------------------------------
   // link state and event pulses
   // ------------------------------
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         link_up         <= 1'b0;
         link_up_pulse   <= 1'b0;
         link_down_pulse <= 1'b0;
      end else begin
         link_up_pulse   <= go_up & ~any_seq;
         link_down_pulse <= link_up & any_seq;   // only a real drop counts
         if (any_seq)    link_up <= 1'b0;        // down wins over up
         else if (go_up) link_up <= 1'b1;
      end
   end

endmodule

// ==== src/efifo_stats.sv ====
`timescale 1ns/1ps
// ------------------------------
// saturating delete, insert, overflow counters
// ------------------------------
module efifo_stats
   import efifo_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n,
   input  logic      delete_evt,
   input  logic      insert_evt,
   input  logic      overflow_evt,
   output stat_cnt_t delete_cnt,
   output stat_cnt_t insert_cnt,
   output stat_cnt_t overflow_cnt
);

   logic [2:0] evt;
   stat_cnt_t  cnt [3];

   assign evt = {overflow_evt, insert_evt, delete_evt};

   // stick at 255
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < 3; i++) cnt[i] <= '0;
      end else begin
         for (int i = 0; i < 3; i++) begin
            if (evt[i] && !(&cnt[i])) cnt[i] <= cnt[i] + 1'b1;
         end
      end
   end

   assign delete_cnt   = cnt[0];
   assign insert_cnt   = cnt[1];
   assign overflow_cnt = cnt[2];

endmodule

// ==== src/efifo_align.sv ====
`timescale 1ns/1ps
// ------------------------------
// receive elastic buffer top
// write side, fifo, read side, link state and stats
// ------------------------------
module efifo_align
   import efifo_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n,
   input  word_t     in_word,          // decoded word from pcs
   input  logic      in_valid,
   input  logic      credit_return,
   output word_t     out_word,
   output logic      out_valid,
   output logic      link_up,
   output logic      link_up_pulse,
   output logic      link_down_pulse,
   output stat_cnt_t delete_cnt,
   output stat_cnt_t insert_cnt,
   output stat_cnt_t overflow_cnt
);

   word_t      wr_word;
   word_t      rd_word;
   used_t      used;
   logic       wr_en, wr_valid, rd_en;
   logic       empty, full, flush;
   logic       delete_evt, insert_evt, overflow_evt, lane_ok;
   logic [3:0] seq_evt;

   assign flush = ~link_up;   // fifo held clear while down

   efifo_write_ctrl u_write (.clk, .rst_n, .in_word, .in_valid, .used, .full, .wr_en,
                             .wr_word, .wr_valid, .delete_evt, .overflow_evt, .lane_ok);

   efifo_fifo #(.DEPTH(FIFO_DEPTH)) u_fifo (.clk, .rst_n, .flush, .wr_en, .wr_word,
                                            .rd_en, .rd_word, .used, .empty, .full);

   efifo_read_ctrl u_read (.clk, .rst_n, .used, .empty, .rd_en, .rd_word,
                           .credit_return, .out_word, .out_valid, .insert_evt);

   // sequence events watch the write stage
   efifo_prim_seq u_prim_seq (.clk, .rst_n, .wr_word, .wr_valid, .seq_evt);

   efifo_link_fsm u_link (.clk, .rst_n, .lane_ok, .wr_word, .seq_evt, .link_up,
                          .link_up_pulse, .link_down_pulse);

   efifo_stats u_stats (.clk, .rst_n, .delete_evt, .insert_evt, .overflow_evt,
                        .delete_cnt, .insert_cnt, .overflow_cnt);

endmodule

// ==== bench/efifo_align_tasks.svh ====
// ------------------------------
// directed tests for the elastic buffer
// word builders, drive helpers, one task per test
// ------------------------------
`ifndef EFIFO_ALIGN_TASKS_SVH
`define EFIFO_ALIGN_TASKS_SVH

   // ------------------------------
   // word builders
   // ------------------------------
   function automatic word_t idle_word();
      word_t w;
      w            = '0;
      w.lane0.idle = 1'b1;
      w.lane1.idle = 1'b1;
      w.data       = IDLE_DATA;
      return w;
   endfunction

   function automatic word_t nos_word();
      word_t w;
      w                      = '0;
      w.lane0.prim[PRIM_NOS] = 1'b1;
      w.lane1.prim[PRIM_NOS] = 1'b1;
      w.data                 = NOS_DATA;
      return w;
   endfunction

   function automatic word_t data_word();
      word_t w;
      w            = '0;
      w.lane0.data = 1'b1;
      w.lane1.data = 1'b1;
      w.data       = {$random(seed), $random(seed)};   // random payload
      return w;
   endfunction

   // idle pair or matching sequence pair, no code violation
   function automatic logic word_is_ccs(input word_t w);
      logic clean;
      logic idle_pair;
      logic seq_pair;
      clean     = !w.lane0.code_viol && !w.lane1.code_viol;
      idle_pair = w.lane0.idle && w.lane1.idle;
      seq_pair  = (w.lane0.prim != '0) && (w.lane0.prim == w.lane1.prim);
      return clean && (idle_pair || seq_pair);
   endfunction

   function automatic logic [63:0] ccs_data(input word_t w);
      case (w.lane0.prim)
         4'b0001 << PRIM_NOS: return NOS_DATA;
         4'b0001 << PRIM_OLS: return OLS_DATA;
         4'b0001 << PRIM_LR:  return LR_DATA;
         4'b0001 << PRIM_LRR: return LRR_DATA;
         default:             return IDLE_DATA;
      endcase
   endfunction

   // ------------------------------
   // drive helpers
   // ------------------------------
   task automatic drive_word(input word_t w, input logic valid, input logic credit);
      @(negedge clk);
      in_word       = w;
      in_valid      = valid;
      credit_return = credit;
   endtask

   task automatic send_data(input int n, input logic credit, input logic track);
      word_t w;
      for (int i = 0; i < n; i++) begin
         w = data_word();
         drive_word(w, 1'b1, credit);
         if (track) sb.push_back(w);   // untracked words are meant to be lost
      end
   endtask

   task automatic send_idles(input int n, input logic valid, input logic credit);
      repeat (n) drive_word(idle_word(), valid, credit);
   endtask

   // data words with an idle ccs after each
   task automatic send_pairs(input int n, input logic credit);
      repeat (n) begin
         send_data(1, credit, 1'b1);
         send_idles(1, 1'b1, credit);
      end
   endtask

   task automatic bring_up();
      int n;
      n = 0;
      while (!link_up && n < LINKUP_IDLES + 4) begin
         drive_word(idle_word(), 1'b1, 1'b1);
         n++;
      end
      check("link_up", link_up, 1'b1);
   endtask

   // idles with credits until every tracked word came out
   task automatic drain(input logic valid);
      int n;
      n = 0;
      while (sb.size() != 0 && n < DRAIN_MAX) begin
         drive_word(idle_word(), valid, 1'b1);
         n++;
      end
      if (sb.size() != 0) fail_stop("data words stuck in the buffer");
   endtask

   // ------------------------------
   // tests
   // ------------------------------
   task automatic reset_values();
      drive_word(idle_word(), 1'b0, 1'b0);
      check("out_valid", out_valid, 1'b0);
      check("link_up", link_up, 1'b0);
      check("delete_cnt", delete_cnt, 0);
      check("insert_cnt", insert_cnt, 0);
      check("overflow_cnt", overflow_cnt, 0);
   endtask

   task automatic link_up_down();
      int ups;
      int downs;
      ups   = up_pulses;
      downs = down_pulses;
      send_idles(LINKUP_IDLES - 1, 1'b1, 1'b0);
      send_idles(2, 1'b0, 1'b0);                    // let the last idle settle
      check("link_up", link_up, 1'b0);              // one idle short
      send_idles(1, 1'b1, 1'b0);
      send_idles(2, 1'b0, 1'b0);
      check("link_up", link_up, 1'b1);
      send_idles(4, 1'b1, 1'b0);
      check("link_up_pulse", up_pulses - ups, 1);
      repeat (3) drive_word(nos_word(), 1'b1, 1'b0);
      send_idles(3, 1'b1, 1'b0);
      check("link_up", link_up, 1'b0);
      check("link_down_pulse", down_pulses - downs, 1);
   endtask

   task automatic pass_through();
      bring_up();
      send_data(40, 1'b1, 1'b1);
      drain(1'b1);
      check("delete_cnt", delete_cnt, 0);
      check("insert_cnt", insert_cnt, 0);
   endtask

   task automatic delete_on_backpressure();
      stat_cnt_t del0;
      del0 = delete_cnt;
      send_pairs(8, 1'b0);     // no credits, fifo climbs past the high mark
      drain(1'b1);
      check("delete_cnt raised", delete_cnt > del0, 1'b1);
   endtask

   task automatic insert_on_underrun();
      stat_cnt_t ins0;
      int        out0;
      send_pairs(10, 1'b1);
      send_idles(12, 1'b1, 1'b1);   // idle tail, last words below low mark
      ins0 = insert_cnt;
      out0 = out_cnt;
      drain(1'b0);                  // input stopped
      send_idles(60, 1'b0, 1'b1);
      check("insert_cnt raised", insert_cnt > ins0, 1'b1);
      check("out_valid beyond fifo depth", out_cnt - out0 > FIFO_DEPTH, 1'b1);
      check("last_ccs_out", last_ccs_out, idle_word());
   endtask

   task automatic credits_and_overflow();
      stat_cnt_t ovf0;
      int        out0;
      send_idles(12, 1'b0, 1'b0);   // inserts use up the last credits
      ovf0 = overflow_cnt;
      out0 = out_cnt;
      send_data(FIFO_DEPTH + 8, 1'b0, 1'b0);
      send_idles(4, 1'b0, 1'b0);
      check("out_valid without credit", out_cnt - out0, 0);
      check("overflow_cnt raised", overflow_cnt > ovf0, 1'b1);
   endtask

`endif

// ==== bench/efifo_align_tb.sv ====
`timescale 1ns/1ps
// ------------------------------
// testbench for the receive elastic buffer
// clock, reset, output monitor and test order
// ------------------------------
module efifo_align_tb
   import efifo_pkg::*;
();
   localparam int CLK_PERIOD = 8;
   localparam int DRAIN_MAX  = 200;   // cycles allowed to empty the scoreboard
   // words driven by all tests, drains counted at their limit
   localparam int TEST_CYCLES = 3 * (LINKUP_IDLES + 4) + 3 + 40 + 16 + 20 + 12 + 60
                                + 12 + 40 + 4 + 3 * DRAIN_MAX;
   localparam int WATCHDOG_NS = 2 * TEST_CYCLES * CLK_PERIOD;

   logic      clk;
   logic      rst_n;
   word_t     in_word;
   logic      in_valid;
   logic      credit_return;
   word_t     out_word;
   logic      out_valid;
   logic      link_up, link_up_pulse, link_down_pulse;
   stat_cnt_t delete_cnt, insert_cnt, overflow_cnt;

   integer    seed;
   word_t     sb [$];            // data words owed by the dut, in order
   int        out_cnt     = 0;   // out_valid cycles so far
   int        ret_cnt     = 0;   // credit_return cycles seen by the dut
   int        up_pulses   = 0;
   int        down_pulses = 0;
   word_t     last_ccs_out;

   efifo_align UUT (.clk, .rst_n, .in_word, .in_valid, .credit_return, .out_word,
                    .out_valid, .link_up, .link_up_pulse, .link_down_pulse,
                    .delete_cnt, .insert_cnt, .overflow_cnt);

   task automatic fail_stop(input string why);
      $display("%s", why);
      $display("TEST FAILED");
      $fatal(1);
   endtask

   task automatic check(input string name, input logic [95:0] actual,
                        input logic [95:0] expected);
      if (actual !== expected)
         fail_stop($sformatf("Mismatch %s: got 0x%0h expected 0x%0h",
                             name, actual, expected));
   endtask

   `include "efifo_align_tasks.svh"

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   initial begin
      #(WATCHDOG_NS);
      fail_stop("timeout, the tests did not finish in time");
   end

   // credits counted at the edge that takes them in
   always @(posedge clk) begin
      if (credit_return) ret_cnt++;
   end

   // ------------------------------
   // output monitor
   // ------------------------------
   always @(negedge clk) begin
      if (link_up_pulse) up_pulses++;
      if (link_down_pulse) down_pulses++;
      if (out_valid) begin
         out_cnt++;
         check("out_valid count", out_cnt <= CREDIT_INIT + ret_cnt, 1'b1);
         if (word_is_ccs(out_word)) begin
            last_ccs_out = out_word;                      // inserted or passed ccs
            check("out_word.data", out_word.data, ccs_data(out_word));
         end else if (sb.size() == 0) begin
            fail_stop("data word at the output that was never sent");
         end else begin
            check("out_word", out_word, sb.pop_front());  // order and value
         end
      end
   end

   initial begin
      seed          = 39;
      rst_n         = 1'b0;
      in_word       = '0;
      in_valid      = 1'b0;
      credit_return = 1'b0;
      last_ccs_out  = '0;
      repeat (2) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      reset_values();
      link_up_down();
      pass_through();
      delete_on_backpressure();
      insert_on_underrun();
      credits_and_overflow();
      check("scoreboard size", sb.size(), 0);
      $display("TEST OK");
      $finish;
   end

endmodule

// ==== efifo_align.f ====
+incdir+bench
src/efifo_pkg.sv
src/efifo_fifo.sv
src/efifo_write_ctrl.sv
src/efifo_read_ctrl.sv
src/efifo_prim_seq.sv
src/efifo_link_fsm.sv
src/efifo_stats.sv
src/efifo_align.sv
bench/efifo_align_tb.sv
